// File: hw/cap_cfg_pkg.sv
/*
 * Capture buffer configuration
 * Lane geometry, field widths and the command opcode set
 */

`default_nettype none

package cap_cfg_pkg;

    // ------------------------------
    // Row geometry
    // ------------------------------
    parameter int lanes      = 8;
    parameter int sample_w   = 9;
    parameter int pairs      = lanes / 2;
    parameter int pair_w     = 2 * sample_w;

    // Address field carried in commands and responses
    parameter int max_addr_w = 15;

    // Command opcodes
    typedef enum logic [1:0] {
        op_write_sweep = 2'd0,
        op_read_sweep  = 2'd1,
        op_mgmt_read   = 2'd2
    } cap_op_e;

endpackage

`default_nettype wire

// File: hw/cap_types_pkg.sv
/*
 * Capture buffer transfer types
 * Command word, memory row views, read stream beat and
 * management response
 */

`default_nettype none

package cap_types_pkg;

    import cap_cfg_pkg::*;

    // Command from the control port, 17 bits
    typedef struct packed {
        cap_op_e                 op;
        logic [max_addr_w-1:0]   addr;
    } cap_cmd_t;

    // ------------------------------
    // One memory row, 72 bits
    // ------------------------------
    // Both views run from the top bit down, so lane 2k lands in the
    // upper half of pair k
    typedef union packed {
        logic [0:lanes-1][sample_w-1:0] lane;
        logic [0:pairs-1][pair_w-1:0]   pair;
    } cap_row_u;

    // Read stream beat, 34 bits
    typedef struct packed {
        logic [pair_w-1:0]       pair;
        logic [max_addr_w-1:0]   addr;
        logic                    last;
    } cap_beat_t;

    // Management read result, 87 bits
    typedef struct packed {
        logic [max_addr_w-1:0]   addr;
        cap_row_u                row;
    } cap_mgmt_rsp_t;

endpackage

`default_nettype wire

// File: hw/addr_counter.sv
/*
 * Sweep address counter
 * Steps through every row address and flags the top one
 */

`timescale 1ns/1ps
`default_nettype none

module addr_counter #(
    parameter int ADDR_W = 5
)
(
    input  logic                rclk,
    input  logic                rrstn,
    input  logic                clear,
    input  logic                advance,
    output logic [ADDR_W-1:0]   addr,
    output logic                last
);

    // Natural rollover takes the top address back to zero
    always_ff @(posedge rclk or negedge rrstn)
    begin
        if (!rrstn)
            addr <= '0;
        else if (clear)
            addr <= '0;
        else if (advance)
            addr <= addr + 1'b1;
    end

    assign last = &addr;

    a_no_clear_advance : assert property (@(posedge rclk) disable iff (!rrstn)
        !(clear && advance));

endmodule

`default_nettype wire

// File: hw/lane_sram.sv
/*
 * Row memory
 * Single port, one full row per address, read data registered
 */

`timescale 1ns/1ps
`default_nettype none

module lane_sram
    import cap_types_pkg::*;
#(
    parameter int ADDR_W = 5
)
(
    input  logic                rclk,
    input  logic                en,
    input  logic                we,
    input  logic [ADDR_W-1:0]   addr,
    input  cap_row_u            wdata,
    output cap_row_u            rdata
);

    localparam int depth = 2 ** ADDR_W;

    cap_row_u mem [depth];

    // rdata keeps its value until the next read strobe
    always_ff @(posedge rclk)
    begin
        if (en)
        begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/pair_packer.sv
/*
 * Read stream packer
 * Holds one row and sends it out as four lane-pair beats
 * under valid/ready flow control
 */

`timescale 1ns/1ps
`default_nettype none

module pair_packer
    import cap_cfg_pkg::*, cap_types_pkg::*;
#(
    parameter int ADDR_W = 5
)
(
    input  logic                rclk,
    input  logic                rrstn,

    input  logic                row_load,
    input  cap_row_u            row,
    input  logic [ADDR_W-1:0]   row_addr,
    input  logic                row_last,
    output logic                row_free,

    output cap_beat_t           beat,
    output logic                beat_valid,
    input  logic                beat_ready,
    output logic                beat_done
);

    localparam int idx_w = $clog2(pairs);

    logic                full;
    logic [idx_w-1:0]    idx;
    logic                at_end;
    logic                xfer;
    cap_row_u            row_q;
    logic [ADDR_W-1:0]   addr_q;
    logic                last_q;

    assign at_end = (idx == idx_w'(pairs - 1));
    assign xfer   = beat_valid && beat_ready;

    // Free when empty, or when the final pair leaves this cycle
    assign row_free = !full || (xfer && at_end);

    assign beat_valid = full;
    assign beat.pair  = row_q.pair[idx];
    assign beat.addr  = max_addr_w'(addr_q);
    assign beat.last  = last_q && at_end;
    assign beat_done  = xfer && beat.last;

    // ------------------------------
    // Occupancy and pair index
    // ------------------------------
    always_ff @(posedge rclk or negedge rrstn)
    begin
        if (!rrstn)
        begin
            full <= 1'b0;
            idx  <= '0;
        end
        else if (row_load)
        begin
            full <= 1'b1;
            idx  <= '0;
        end
        else if (xfer)
        begin
            if (at_end)
                full <= 1'b0;
            idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge rclk)
    begin
        if (row_load)
        begin
            row_q  <= row;
            addr_q <= row_addr;
            last_q <= row_last;
        end
    end

    a_beat_hold : assert property (@(posedge rclk) disable iff (!rrstn)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat));

endmodule

`default_nettype wire

// File: hw/sweep_fsm.sv
/*
 * Capture buffer sequencer
 * Takes one command at a time and runs the write sweep, read sweep
 * or management read against the row memory
 */

`timescale 1ns/1ps
`default_nettype none

module sweep_fsm
    import cap_cfg_pkg::*, cap_types_pkg::*;
#(
    parameter int ADDR_W = 5
)
(
    input  logic                rclk,
    input  logic                rrstn,

    input  cap_cmd_t            cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,

    input  logic [ADDR_W-1:0]   cnt_addr,
    input  logic                cnt_last,
    output logic                cnt_clear,
    output logic                cnt_advance,

    output logic                mem_en,
    output logic                mem_we,
    output logic [ADDR_W-1:0]   mem_addr,
    input  cap_row_u            rd_row,

    input  logic                row_free,
    output logic                row_load,
    output logic [ADDR_W-1:0]   row_addr,
    output logic                row_last,
    input  logic                beat_done,

    output cap_mgmt_rsp_t       mgmt_rsp,
    output logic                mgmt_valid,
    output logic                write_done,
    output logic                read_done
);

    typedef enum logic [2:0] {
        idle,
        writing,
        reading,
        draining,
        mgmt_issue,
        mgmt_wait
    } state_e;

    state_e              state;
    state_e              state_d;
    logic                accept;
    logic                issue;
    logic                pend;
    logic [ADDR_W-1:0]   pend_addr;
    logic                pend_last;
    logic [ADDR_W-1:0]   mgmt_addr;

    assign cmd_ready = (state == idle);
    assign accept    = cmd_valid && cmd_ready;

    // Read sweep issues only when the packer can take a row
    assign issue = (state == reading) && row_free;

    // ------------------------------
    // Counter and memory strobes
    // ------------------------------
    assign cnt_clear   = accept;
    assign cnt_advance = (state == writing) || issue;

    assign mem_en   = (state == writing) || issue || (state == mgmt_issue);
    assign mem_we   = (state == writing);
    assign mem_addr = (state == mgmt_issue) ? mgmt_addr : cnt_addr;

    // Pending row moves into the packer once it frees up
    assign row_load = pend && row_free;
    assign row_addr = pend_addr;
    assign row_last = pend_last;

    // Memory data is on rd_row in mgmt_wait
    assign mgmt_valid    = (state == mgmt_wait);
    assign mgmt_rsp.addr = max_addr_w'(mgmt_addr);
    assign mgmt_rsp.row  = rd_row;

    always_comb
    begin
        state_d = state;
        case (state)
            idle:
            begin
                if (accept)
                begin
                    case (cmd.op)
                        op_write_sweep: state_d = writing;
                        op_read_sweep:  state_d = reading;
                        op_mgmt_read:   state_d = mgmt_issue;
                        default:        state_d = idle;
                    endcase
                end
            end
            writing:
            begin
                if (cnt_last)
                    state_d = idle;
            end
            reading:
            begin
                if (issue && cnt_last)
                    state_d = draining;
            end
            draining:
            begin
                if (beat_done)
                    state_d = idle;
            end
            mgmt_issue: state_d = mgmt_wait;
            mgmt_wait:  state_d = idle;
            default:    state_d = idle;
        endcase
    end

    always_ff @(posedge rclk or negedge rrstn)
    begin
        if (!rrstn)
        begin
            state      <= idle;
            pend       <= 1'b0;
            write_done <= 1'b0;
            read_done  <= 1'b0;
        end
        else
        begin
            state      <= state_d;
            write_done <= (state == writing) && cnt_last;
            read_done  <= (state == draining) && beat_done;
            if (issue)
                pend <= 1'b1;
            else if (row_load)
                pend <= 1'b0;
        end
    end

    // Address and tag of the row in the memory stage
    always_ff @(posedge rclk)
    begin
        if (accept)
            mgmt_addr <= cmd.addr[ADDR_W-1:0];
        if (issue)
        begin
            pend_addr <= cnt_addr;
            pend_last <= cnt_last;
        end
    end

    // No read row waits for the packer while the sweep writes
    a_we_in_write : assert property (@(posedge rclk) disable iff (!rrstn)
        mem_we |-> !pend);

    // Read sweep fully drained before a new command is taken
    a_ready_in_idle : assert property (@(posedge rclk) disable iff (!rrstn)
        cmd_ready |-> !pend && !beat_done);

endmodule

`default_nettype wire

// File: hw/capture_top.sv
/*
 * Capture buffer top level
 * Sequencer, address counter, row memory and read packer
 */

`timescale 1ns/1ps
`default_nettype none

module capture_top
    import cap_types_pkg::*;
#(
    parameter int ADDR_W = 5
)
(
    input  logic            rclk,
    input  logic            rrstn,

    input  cap_cmd_t        cmd,
    input  logic            cmd_valid,
    output logic            cmd_ready,

    input  cap_row_u        samples,

    output cap_beat_t       beat,
    output logic            beat_valid,
    input  logic            beat_ready,

    output cap_mgmt_rsp_t   mgmt_rsp,
    output logic            mgmt_valid,
    output logic            write_done,
    output logic            read_done
);

    logic                cnt_clear;
    logic                cnt_advance;
    logic [ADDR_W-1:0]   cnt_addr;
    logic                cnt_last;

    logic                mem_en;
    logic                mem_we;
    logic [ADDR_W-1:0]   mem_addr;
    cap_row_u            rd_row;

    logic                row_free;
    logic                row_load;
    logic [ADDR_W-1:0]   row_addr;
    logic                row_last;
    logic                beat_done;

    sweep_fsm #(
        .ADDR_W      (ADDR_W)
    ) u_fsm (
        .rclk        (rclk),
        .rrstn       (rrstn),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cnt_addr    (cnt_addr),
        .cnt_last    (cnt_last),
        .cnt_clear   (cnt_clear),
        .cnt_advance (cnt_advance),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .rd_row      (rd_row),
        .row_free    (row_free),
        .row_load    (row_load),
        .row_addr    (row_addr),
        .row_last    (row_last),
        .beat_done   (beat_done),
        .mgmt_rsp    (mgmt_rsp),
        .mgmt_valid  (mgmt_valid),
        .write_done  (write_done),
        .read_done   (read_done)
    );

    addr_counter #(
        .ADDR_W  (ADDR_W)
    ) u_cnt (
        .rclk    (rclk),
        .rrstn   (rrstn),
        .clear   (cnt_clear),
        .advance (cnt_advance),
        .addr    (cnt_addr),
        .last    (cnt_last)
    );

    // Samples go straight to the write port
    lane_sram #(
        .ADDR_W (ADDR_W)
    ) u_sram (
        .rclk   (rclk),
        .en     (mem_en),
        .we     (mem_we),
        .addr   (mem_addr),
        .wdata  (samples),
        .rdata  (rd_row)
    );

    pair_packer #(
        .ADDR_W     (ADDR_W)
    ) u_pack (
        .rclk       (rclk),
        .rrstn      (rrstn),
        .row_load   (row_load),
        .row        (rd_row),
        .row_addr   (row_addr),
        .row_last   (row_last),
        .row_free   (row_free),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .beat_done  (beat_done)
    );

endmodule

`default_nettype wire

// File: dv/capture_tb.sv
/*
 * Capture buffer testbench
 * Runs a table of write sweeps, read sweeps and management reads
 * against a row model and checks every response
 */

`timescale 1ns/1ps
`default_nettype none

module capture_tb
    import cap_cfg_pkg::*, cap_types_pkg::*;
;

    localparam int addr_w  = 5;
    localparam int depth   = 2 ** addr_w;
    localparam int n_steps = 10;

    typedef struct packed {
        cap_op_e                 op;
        logic [max_addr_w-1:0]   addr;
        logic [1:0]              bp;
        logic                    queued;
    } step_t;

    logic            rclk = 1'b0;
    logic            rrstn;
    cap_cmd_t        cmd;
    logic            cmd_valid;
    logic            cmd_ready;
    cap_row_u        samples;
    cap_beat_t       beat;
    logic            beat_valid;
    logic            beat_ready;
    cap_mgmt_rsp_t   mgmt_rsp;
    logic            mgmt_valid;
    logic            write_done;
    logic            read_done;

    cap_row_u        model [depth];
    step_t           steps [n_steps];
    integer          seed;
    int              row_errs;
    int              beat_errs;
    int              flag_errs;

    capture_top #(
        .ADDR_W     (addr_w)
    ) u_dut (
        .rclk       (rclk),
        .rrstn      (rrstn),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .samples    (samples),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .mgmt_rsp   (mgmt_rsp),
        .mgmt_valid (mgmt_valid),
        .write_done (write_done),
        .read_done  (read_done)
    );

    always #10 rclk = ~rclk;

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            flag_errs++;
            $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task check_row(input cap_row_u got, input cap_row_u exp, input string what);
        if (got !== exp)
        begin
            row_errs++;
            $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task check_beat(input cap_beat_t got, input cap_beat_t exp, input string what);
        if (got !== exp)
        begin
            beat_errs++;
            $display("** Error @ %0t: %s is pair %h addr %0d last %b, expected %h %0d %b",
                $time, what, got.pair, got.addr, got.last, exp.pair, exp.addr, exp.last);
        end
    endtask

    task abort_run(input string why);
        $display("Run stopped at %0t: %s", $time, why);
        $display("Errors: rows %0d, beats %0d, flags %0d", row_errs, beat_errs, flag_errs);
        $display("CHECKS FAILED");
        $finish;
    endtask

    function automatic step_t make_step(input cap_op_e op, input int addr,
                                        input int bp, input logic queued);
        step_t s;
        s.op     = op;
        s.addr   = max_addr_w'(addr);
        s.bp     = 2'(bp);
        s.queued = queued;
        return s;
    endfunction

    // 0 never stalls, 1 stalls about half the time, 2 is ready one cycle in four
    function logic pick_ready(input logic [1:0] bp);
        integer v;
        v = $random(seed);
        case (bp)
            2'd1:    return v[0];
            2'd2:    return (v[1:0] == 2'b00);
            default: return 1'b1;
        endcase
    endfunction

    task fill_model;
        cap_row_u r;
        integer   v;
        for (int a = 0; a < depth; a++)
        begin
            for (int l = 0; l < lanes; l++)
            begin
                v = $random(seed);
                r.lane[l] = v[sample_w-1:0];
            end
            model[a] = r;
        end
    endtask

    // Returns on the accepting edge with cmd_valid dropped
    task send_cmd(input cap_cmd_t c);
        int cyc;
        @(posedge rclk);
        cmd       <= c;
        cmd_valid <= 1'b1;
        cyc = 0;
        @(negedge rclk);
        while (!cmd_ready && cyc < 64)
        begin
            @(negedge rclk);
            cyc++;
        end
        if (!cmd_ready)
            abort_run("command was never accepted");
        else
        begin
            @(posedge rclk);
            cmd_valid <= 1'b0;
        end
    endtask

    // Response lands in the second cycle after the accepting edge
    task check_mgmt_rsp(input logic [max_addr_w-1:0] addr);
        int a;
        a = addr % depth;
        @(negedge rclk);
        check_flag(mgmt_valid, 1'b0, "mgmt_valid one cycle after accept");
        check_flag(read_done, 1'b0, "read_done second cycle");
        @(negedge rclk);
        check_flag(mgmt_valid, 1'b1, "mgmt_valid two cycles after accept");
        check_flag(mgmt_rsp.addr == max_addr_w'(a), 1'b1, "mgmt address");
        check_row(mgmt_rsp.row, model[a], "mgmt row");
        @(negedge rclk);
        check_flag(mgmt_valid, 1'b0, "mgmt_valid after pulse");
    endtask

    task run_mgmt(input logic [max_addr_w-1:0] addr);
        cap_cmd_t c;
        c.op   = op_mgmt_read;
        c.addr = addr;
        send_cmd(c);
        check_mgmt_rsp(addr);
    endtask

    // ------------------------------
    // Write sweep
    // ------------------------------
    task run_write;
        cap_cmd_t c;
        int       cyc;
        fill_model();
        c.op   = op_write_sweep;
        c.addr = '0;
        send_cmd(c);
        for (int k = 0; k < depth; k++)
        begin
            samples <= model[k];
            @(negedge rclk);
            check_flag(write_done, 1'b0, "write_done during sweep");
            check_flag(cmd_ready, 1'b0, "cmd_ready during write sweep");
            @(posedge rclk);
        end
        samples <= ~model[0];
        cyc = 0;
        @(negedge rclk);
        while (write_done !== 1'b1 && cyc < 16)
        begin
            @(negedge rclk);
            cyc++;
        end
        if (write_done !== 1'b1)
            abort_run("write_done never pulsed");
        else
        begin
            check_flag(cyc == 0, 1'b1, "write_done right after last write");
            check_flag(cmd_ready, 1'b1, "cmd_ready with write_done");
            @(negedge rclk);
            check_flag(write_done, 1'b0, "write_done after pulse");
        end
    endtask

    // ------------------------------
    // Read sweep, optionally with a management read held waiting
    // ------------------------------
    task run_read(input logic [1:0] bp, input logic queued,
                  input logic [max_addr_w-1:0] qaddr);
        cap_cmd_t  c;
        cap_beat_t exp;
        cap_beat_t held;
        cap_row_u  r;
        logic      holding;
        logic      seen_done;
        int        n;
        int        cyc;
        int        last_cyc;
        int        a;
        int        k;
        c.op   = op_read_sweep;
        c.addr = '0;
        send_cmd(c);
        if (queued)
        begin
            cmd.op    <= op_mgmt_read;
            cmd.addr  <= qaddr;
            cmd_valid <= 1'b1;
        end
        n = 0;
        cyc = 0;
        last_cyc = -1;
        holding = 1'b0;
        seen_done = 1'b0;
        while (!seen_done && cyc < 2000)
        begin
            beat_ready <= pick_ready(bp);
            @(negedge rclk);
            cyc++;
            if (holding)
            begin
                check_flag(beat_valid, 1'b1, "beat_valid under stall");
                check_beat(beat, held, "held beat");
            end
            holding = beat_valid && !beat_ready;
            held = beat;
            if (read_done)
            begin
                seen_done = 1'b1;
                check_flag(n == depth * pairs, 1'b1, "all beats before read_done");
                check_flag(cyc == last_cyc + 1, 1'b1, "read_done after final beat");
            end
            else if (queued)
            begin
                check_flag(cmd_ready, 1'b0, "cmd_ready during read sweep");
                check_flag(mgmt_valid, 1'b0, "mgmt_valid during read sweep");
            end
            if (beat_valid && beat_ready)
            begin
                if (n < depth * pairs)
                begin
                    a = n / pairs;
                    k = n % pairs;
                    r = model[a];
                    // Lane 2k is the upper half of pair k
                    exp.pair = {r.lane[2*k], r.lane[2*k+1]};
                    exp.addr = max_addr_w'(a);
                    exp.last = (n == depth * pairs - 1);
                    check_beat(beat, exp, "read beat");
                end
                else
                begin
                    beat_errs++;
                    $display("Extra beat after the final one at %0t", $time);
                end
                n++;
                last_cyc = cyc;
            end
            @(posedge rclk);
        end
        if (!seen_done)
            abort_run("read_done never pulsed");
        else if (queued)
        begin
            // Held command goes in on this edge
            cmd_valid <= 1'b0;
            check_mgmt_rsp(qaddr);
        end
        else
        begin
            @(negedge rclk);
            check_flag(read_done, 1'b0, "read_done after pulse");
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial
    begin
        seed       = 64;
        row_errs   = 0;
        beat_errs  = 0;
        flag_errs  = 0;
        rrstn      = 1'b0;
        cmd        = '0;
        cmd_valid  = 1'b0;
        samples    = '0;
        beat_ready = 1'b0;

        steps[0] = make_step(op_write_sweep, 0, 0, 1'b0);
        steps[1] = make_step(op_mgmt_read, 0, 0, 1'b0);
        steps[2] = make_step(op_mgmt_read, 31, 0, 1'b0);
        steps[3] = make_step(op_mgmt_read, 13, 0, 1'b0);
        steps[4] = make_step(op_read_sweep, 0, 0, 1'b0);
        steps[5] = make_step(op_read_sweep, 0, 1, 1'b0);
        steps[6] = make_step(op_read_sweep, 7, 2, 1'b1);
        steps[7] = make_step(op_mgmt_read, 'h7fe3, 0, 1'b0);
        steps[8] = make_step(op_write_sweep, 0, 0, 1'b0);
        steps[9] = make_step(op_read_sweep, 22, 1, 1'b1);

        repeat (8) @(posedge rclk);
        rrstn <= 1'b1;

        @(negedge rclk);
        check_flag(cmd_ready, 1'b1, "cmd_ready after reset");
        check_flag(beat_valid, 1'b0, "beat_valid after reset");
        check_flag(mgmt_valid, 1'b0, "mgmt_valid after reset");
        check_flag(write_done, 1'b0, "write_done after reset");
        check_flag(read_done, 1'b0, "read_done after reset");

        for (int i = 0; i < n_steps; i++)
        begin
            case (steps[i].op)
                op_write_sweep: run_write();
                op_read_sweep:  run_read(steps[i].bp, steps[i].queued, steps[i].addr);
                default:        run_mgmt(steps[i].addr);
            endcase
        end

        repeat (2) @(posedge rclk);
        $display("Errors: rows %0d, beats %0d, flags %0d", row_errs, beat_errs, flag_errs);
        if (row_errs + beat_errs + flag_errs == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: capture_buf.f
hw/cap_cfg_pkg.sv
hw/cap_types_pkg.sv
hw/addr_counter.sv
hw/lane_sram.sv
hw/pair_packer.sv
hw/sweep_fsm.sv
hw/capture_top.sv
dv/capture_tb.sv

// File: Bender.yml
package:
  name: capture_buf

dependencies: {}

sources:
  # Packages first, then RTL leaves and the top level
  - hw/cap_cfg_pkg.sv
  - hw/cap_types_pkg.sv
  - hw/addr_counter.sv
  - hw/lane_sram.sv
  - hw/pair_packer.sv
  - hw/sweep_fsm.sv
  - hw/capture_top.sv
  - target: test
    files:
      - dv/capture_tb.sv
